/* src/fifo_defs.svh */
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

//##########################################################################
// async fifo sizing
//##########################################################################

// width of one data word
`define FIFO_DW 32

// number of entries, keep to a power of two
`define FIFO_DEPTH 16

// address bits, log2 of depth
// pointers carry one extra wrap bit on top
`define FIFO_AW 4

// prog_full asserts at or above this many entries
`define FIFO_PROG_FULL 8

`endif

/* src/fifo_pkg.sv */
`default_nettype none
`include "fifo_defs.svh"

package fifo_pkg;

   // write strobe and its word, sampled together on wr_clk
   typedef struct packed {
      logic                en;
      logic [`FIFO_DW-1:0] data;
   } wr_req_t;

   // binary and gray pointer pair, only gray crosses domains
   typedef struct packed {
      logic [`FIFO_AW:0] bin;
      logic [`FIFO_AW:0] gray;
   } ptr_t;

   // read side status, timed to rd_clk
   typedef struct packed {
      logic              empty;
      logic [`FIFO_AW:0] count;  // 0..depth
   } rd_status_t;

   // write side status, timed to wr_clk
   typedef struct packed {
      logic              full;
      logic              prog_full;
      logic [`FIFO_AW:0] count;  // 0..depth
   } wr_status_t;

   //##########################################################################
   // gray code helpers shared by both controllers
   //##########################################################################

   function automatic logic [`FIFO_AW:0] bin2gray(input logic [`FIFO_AW:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic logic [`FIFO_AW:0] gray2bin(input logic [`FIFO_AW:0] gray);
      logic [`FIFO_AW:0] bin;
      bin[`FIFO_AW] = gray[`FIFO_AW];  // msb passes straight
      for (int i = `FIFO_AW - 1; i >= 0; i--)
         bin[i] = bin[i+1] ^ gray[i];  // running xor downwards
      return bin;
   endfunction

endpackage

`default_nettype wire

/* src/fifo_dpram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_dpram
  (
   // write port
   input  logic                wr_clk,
   input  logic                wr_en,    // already gated by full
   input  logic [`FIFO_AW-1:0] wr_addr,
   input  logic [`FIFO_DW-1:0] din,
   // read port
   input  logic                rd_clk,
   input  logic                nreset,   // clears the output register only
   input  logic                rd_en,    // already gated by empty
   input  logic [`FIFO_AW-1:0] rd_addr,
   output logic [`FIFO_DW-1:0] dout      // valid one rd_clk after rd_en
   );

   //##########################################################################
   // storage
   //##########################################################################

   logic [`FIFO_DW-1:0] mem [0:`FIFO_DEPTH-1];

   // write side, wr_clk domain
   always_ff @(posedge wr_clk)
   begin
      if (wr_en)
         mem[wr_addr] <= din;
   end

   //##########################################################################
   // registered read, rd_clk domain
   //##########################################################################

   // dout holds the last word read until the next accepted read
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
         dout <= '0;
      else if (rd_en)
         dout <= mem[rd_addr];
   end

   // the entry at rd_addr was written at least two wr_clk edges plus
   // a two stage sync earlier, so it is stable when sampled here

endmodule

`default_nettype wire

/* src/fifo_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_wr_ctrl
  (
   input  logic                 wr_clk,
   input  logic                 nreset,
   input  fifo_pkg::wr_req_t    wr_req,    // only en used here
   input  logic [`FIFO_AW:0]    rd_gray,   // from rd_clk domain
   output fifo_pkg::ptr_t       wr_ptr,
   output logic                 mem_wr_en,
   output fifo_pkg::wr_status_t status
   );

   localparam logic [`FIFO_AW:0] DEPTH     = (`FIFO_AW + 1)'(`FIFO_DEPTH);
   localparam logic [`FIFO_AW:0] PROG_FULL = (`FIFO_AW + 1)'(`FIFO_PROG_FULL);

   logic [`FIFO_AW:0] rd_gray_meta;  // first sync stage
   logic [`FIFO_AW:0] rd_gray_sync;  // second sync stage
   logic [`FIFO_AW:0] rd_bin;        // synced read pointer, binary
   logic [`FIFO_AW:0] wr_bin_next;
   logic [`FIFO_AW:0] count_next;

   //##########################################################################
   // write accept
   //##########################################################################

   // strobe while full is dropped
   assign mem_wr_en = wr_req.en & ~status.full;

   assign wr_bin_next = wr_ptr.bin + {{`FIFO_AW{1'b0}}, mem_wr_en};

   // pointer pair, gray is what the read side sees
   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr.bin  <= '0;
         wr_ptr.gray <= '0;
      end
      else if (mem_wr_en)
      begin
         wr_ptr.bin  <= wr_bin_next;
         wr_ptr.gray <= fifo_pkg::bin2gray(wr_bin_next);  // one bit flips per write
      end
   end

   //##########################################################################
   // read pointer sync
   //##########################################################################

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end
      else
      begin
         rd_gray_meta <= rd_gray;       // may go metastable
         rd_gray_sync <= rd_gray_meta;  // settled copy
      end
   end

   assign rd_bin = fifo_pkg::gray2bin(rd_gray_sync);

   //##########################################################################
   // status
   //##########################################################################

   // wrap bit makes the plain difference correct across rollover
   // stale rd_bin only overstates the count, so full stays safe
   assign count_next = wr_bin_next - rd_bin;

   always_ff @(posedge wr_clk or negedge nreset)
   begin
      if (!nreset)
         status <= '0;
      else
      begin
         status.count     <= count_next;
         status.full      <= (count_next == DEPTH);
         status.prog_full <= (count_next >= PROG_FULL);  // also high when full
      end
   end

endmodule

`default_nettype wire

/* src/fifo_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_rd_ctrl
  (
   input  logic                 rd_clk,
   input  logic                 nreset,
   input  logic                 rd_en,
   input  logic [`FIFO_AW:0]    wr_gray,   // from wr_clk domain
   output fifo_pkg::ptr_t       rd_ptr,
   output logic                 mem_rd_en,
   output fifo_pkg::rd_status_t status
   );

   logic [`FIFO_AW:0] wr_gray_meta;  // first sync stage
   logic [`FIFO_AW:0] wr_gray_sync;  // second sync stage
   logic [`FIFO_AW:0] wr_bin;        // synced write pointer, binary
   logic [`FIFO_AW:0] rd_bin_next;
   logic [`FIFO_AW:0] count_next;

   //##########################################################################
   // read accept
   //##########################################################################

   // strobe while empty is dropped
   assign mem_rd_en = rd_en & ~status.empty;

   assign rd_bin_next = rd_ptr.bin + {{`FIFO_AW{1'b0}}, mem_rd_en};

   // pointer pair, gray goes back to the write side
   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_ptr.bin  <= '0;
         rd_ptr.gray <= '0;
      end
      else if (mem_rd_en)
      begin
         rd_ptr.bin  <= rd_bin_next;
         rd_ptr.gray <= fifo_pkg::bin2gray(rd_bin_next);
      end
   end

   //##########################################################################
   // write pointer sync
   //##########################################################################

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end
      else
      begin
         wr_gray_meta <= wr_gray;       // may go metastable
         wr_gray_sync <= wr_gray_meta;  // settled copy
      end
   end

   assign wr_bin = fifo_pkg::gray2bin(wr_gray_sync);

   //##########################################################################
   // status
   //##########################################################################

   // stale wr_bin only understates the count
   // so empty can linger but never clears early
   assign count_next = wr_bin - rd_bin_next;

   always_ff @(posedge rd_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         status.empty <= 1'b1;  // nothing stored out of reset
         status.count <= '0;
      end
      else
      begin
         status.count <= count_next;
         status.empty <= (count_next == '0);
      end
   end

   // words appear here two to three rd_clk edges after the write,
   // depending on where the wr_clk edge lands in the rd_clk period

endmodule

`default_nettype wire

/* src/fifo_generic.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_generic
  (
   input  logic                 nreset,     // async, both domains
   // write domain
   input  logic                 wr_clk,
   input  fifo_pkg::wr_req_t    wr_req,
   // read domain
   input  logic                 rd_clk,
   input  logic                 rd_en,
   output logic [`FIFO_DW-1:0]  dout,
   // status
   output fifo_pkg::wr_status_t wr_status,  // wr_clk timed
   output fifo_pkg::rd_status_t rd_status   // rd_clk timed
   );

   fifo_pkg::ptr_t wr_ptr;      // wr_clk domain
   fifo_pkg::ptr_t rd_ptr;      // rd_clk domain
   logic           mem_wr_en;
   logic           mem_rd_en;

   //##########################################################################
   // controllers, gray pointers cross over
   //##########################################################################

   fifo_wr_ctrl u_wr_ctrl
     (
      .wr_clk    (wr_clk),
      .nreset    (nreset),
      .wr_req    (wr_req),
      .rd_gray   (rd_ptr.gray),
      .wr_ptr    (wr_ptr),
      .mem_wr_en (mem_wr_en),
      .status    (wr_status)
      );

   fifo_rd_ctrl u_rd_ctrl
     (
      .rd_clk    (rd_clk),
      .nreset    (nreset),
      .rd_en     (rd_en),
      .wr_gray   (wr_ptr.gray),
      .rd_ptr    (rd_ptr),
      .mem_rd_en (mem_rd_en),
      .status    (rd_status)
      );

   //##########################################################################
   // storage, addressed by pointer low bits
   //##########################################################################

   fifo_dpram u_dpram
     (
      .wr_clk  (wr_clk),
      .wr_en   (mem_wr_en),
      .wr_addr (wr_ptr.bin[`FIFO_AW-1:0]),  // wrap bit dropped
      .din     (wr_req.data),
      .rd_clk  (rd_clk),
      .nreset  (nreset),
      .rd_en   (mem_rd_en),
      .rd_addr (rd_ptr.bin[`FIFO_AW-1:0]),
      .dout    (dout)
      );

endmodule

`default_nettype wire

/* src/fifo_async.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_async
  (
   // reset for both clock domains
   input  logic                 nreset,
   // write port
   input  logic                 wr_clk,
   input  fifo_pkg::wr_req_t    wr_req,     // en plus data word
   // read port
   input  logic                 rd_clk,
   input  logic                 rd_en,
   output logic [`FIFO_DW-1:0]  dout,       // next rd_clk after rd_en
   // status
   output fifo_pkg::wr_status_t wr_status,  // full, prog_full, count
   output fifo_pkg::rd_status_t rd_status   // empty, count
   );

   //##########################################################################
   // subsystem top
   //##########################################################################

   // internal nets between ports and the fifo core
   fifo_pkg::wr_req_t    core_wr_req;
   logic [`FIFO_DW-1:0]  core_dout;
   fifo_pkg::wr_status_t core_wr_status;
   fifo_pkg::rd_status_t core_rd_status;

   assign core_wr_req = wr_req;       // write strobe and word together
   assign dout        = core_dout;
   assign wr_status   = core_wr_status;
   assign rd_status   = core_rd_status;

   // generic dual clock core
   // memory plus one controller per domain
   fifo_generic u_generic
     (
      .nreset    (nreset),
      .wr_clk    (wr_clk),
      .wr_req    (core_wr_req),
      .rd_clk    (rd_clk),
      .rd_en     (rd_en),
      .dout      (core_dout),
      .wr_status (core_wr_status),
      .rd_status (core_rd_status)
      );

   // full and prog_full follow wr_clk
   // empty and rd count follow rd_clk
   // both flag sets lag the far side by the two stage sync

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
  #(
   parameter int PERIOD_NS = 20  // full period
   )
  (
   output logic clk
   );

   // low at time zero, first rising edge after half a period
   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

/* dv/fifo_async_asserts.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_async_asserts
  (
   input logic                 nreset,
   input logic                 wr_clk,
   input logic                 rd_clk,
   input fifo_pkg::wr_status_t wr_status,
   input fifo_pkg::rd_status_t rd_status
   );

   localparam logic [`FIFO_AW:0] DEPTH = (`FIFO_AW + 1)'(`FIFO_DEPTH);

   // rd_status never moves on a wr_clk edge
   a_full_empty: assert property (@(posedge wr_clk) disable iff (!nreset)
                                  !(wr_status.full && rd_status.empty))
      else $error("full and empty high at the same time");

   a_wr_count: assert property (@(posedge wr_clk) disable iff (!nreset)
                                wr_status.count <= DEPTH)
      else $error("write count above depth");

   a_rd_count: assert property (@(posedge rd_clk) disable iff (!nreset)
                                rd_status.count <= DEPTH)
      else $error("read count above depth");

   a_prog_full: assert property (@(posedge wr_clk) disable iff (!nreset)
                                 wr_status.full |-> wr_status.prog_full)
      else $error("full without prog_full");

endmodule

bind fifo_async fifo_async_asserts u_asserts
  (
   .nreset    (nreset),
   .wr_clk    (wr_clk),
   .rd_clk    (rd_clk),
   .wr_status (wr_status),
   .rd_status (rd_status)
   );

`default_nettype wire

/* dv/fifo_async_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_async_tb;

   localparam logic [31:0] SEED  = 32'h7112ab33;
   localparam int          LIMIT = 400;  // rd_clk cycles allowed for one drain

   logic                 wr_clk;
   logic                 rd_clk;
   logic                 nreset;
   fifo_pkg::wr_req_t    wr_req;
   logic                 rd_en;
   logic [`FIFO_DW-1:0]  dout;
   fifo_pkg::wr_status_t wr_status;
   fifo_pkg::rd_status_t rd_status;

   logic [`FIFO_DW-1:0]  model_q [$];      // reference, oldest word at front
   logic [`FIFO_DW-1:0]  dout_hold;        // last word the model handed out
   logic [31:0]          wr_rng;
   logic [31:0]          rd_rng;
   logic                 rd_accept = 1'b0; // read taken on last rd_clk edge
   int                   writes_done = 0;
   int                   reads_done = 0;
   int                   checks = 0;
   int                   errors = 0;
   int                   timeouts = 0;

   tb_clk_gen #(.PERIOD_NS(20)) u_wr_clk (.clk(wr_clk));
   tb_clk_gen #(.PERIOD_NS(14)) u_rd_clk (.clk(rd_clk));

   fifo_async u_dut
     (
      .nreset    (nreset),
      .wr_clk    (wr_clk),
      .wr_req    (wr_req),
      .rd_clk    (rd_clk),
      .rd_en     (rd_en),
      .dout      (dout),
      .wr_status (wr_status),
      .rd_status (rd_status)
      );

   //##########################################################################
   // helpers
   //##########################################################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // expected word for the next read, first in first out
   function automatic logic [`FIFO_DW-1:0] ref_head();
      return model_q[0];
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // flags plus both counts against the model occupancy
   task automatic check_status(input logic empty, input logic full, input logic prog_full);
      check("empty", 32'(rd_status.empty), 32'(empty));
      check("full", 32'(wr_status.full), 32'(full));
      check("prog_full", 32'(wr_status.prog_full), 32'(prog_full));
      check("rd count", 32'(rd_status.count), 32'(writes_done - reads_done));
      check("wr count", 32'(wr_status.count), 32'(writes_done - reads_done));
   endtask

   task automatic settle();
      repeat (8)  // well past the 2 to 3 edge sync latency
         @(negedge wr_clk);
   endtask

   task automatic write_words(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge wr_clk);
         wr_rng      = xorshift32(wr_rng);
         wr_req.en   = 1'b1;
         wr_req.data = wr_rng;
      end
      @(negedge wr_clk);
      wr_req.en = 1'b0;
   endtask

   // read until every accepted write has come back out
   task automatic drain_all();
      int guard;
      guard = 0;
      @(negedge rd_clk);
      while (reads_done != writes_done && guard < LIMIT)
      begin
         rd_en = 1'b1;
         @(negedge rd_clk);
         guard++;
      end
      rd_en = 1'b0;
      if (reads_done != writes_done)
      begin
         timeouts++;
         $display("Timeout: drain gave up with %0d words unread", writes_done - reads_done);
      end
   endtask

   //##########################################################################
   // model and compare
   //##########################################################################

   always @(posedge wr_clk)
   begin
      if (nreset && wr_req.en && !wr_status.full)  // write the DUT must take
      begin
         model_q.push_back(wr_req.data);
         writes_done = writes_done + 1;
      end
   end

   always @(posedge rd_clk)
   begin
      rd_accept = nreset && rd_en && !rd_status.empty;
      if (rd_accept)
         reads_done = reads_done + 1;
   end

   // dout is settled half an rd_clk after the read edge
   initial
   begin
      forever
      begin
         @(negedge rd_clk);
         if (rd_accept && model_q.size() == 0)
         begin
            errors++;
            $display("** Error at %0d ns: read accepted with nothing written", $time);
         end
         else if (rd_accept)
         begin
            check("dout", dout, ref_head());
            dout_hold = model_q.pop_front();  // held on dout until the next read
         end
      end
   end

   //##########################################################################
   // stimulus
   //##########################################################################

   initial
   begin
      nreset = 1'b0;
      wr_req = '0;
      rd_en  = 1'b0;
      wr_rng = SEED;
      rd_rng = {SEED[15:0], SEED[31:16]};  // second stream, same seed
      repeat (3)
         @(negedge wr_clk);
      nreset = 1'b1;
      settle();
      check_status(1'b1, 1'b0, 1'b0);  // out of reset
      check("dout after reset", dout, 32'd0);
      // random interleaved traffic, writes slightly faster than reads
      fork
         begin
            repeat (300)
            begin
               @(negedge wr_clk);
               wr_rng      = xorshift32(wr_rng);
               wr_req.en   = wr_rng[0] | wr_rng[1];  // ~75 percent
               wr_req.data = wr_rng;
            end
            @(negedge wr_clk);
            wr_req.en = 1'b0;
         end
         begin
            repeat (420)
            begin
               @(negedge rd_clk);
               rd_rng = xorshift32(rd_rng);
               rd_en  = rd_rng[3];                    // ~50 percent
            end
            @(negedge rd_clk);
            rd_en = 1'b0;
         end
      join
      settle();
      check_status(writes_done == reads_done,
                   (writes_done - reads_done) == `FIFO_DEPTH,
                   (writes_done - reads_done) >= `FIFO_PROG_FULL);
      drain_all();
      settle();
      check_status(1'b1, 1'b0, 1'b0);
      // prog_full threshold
      write_words(`FIFO_PROG_FULL - 1);
      settle();
      check_status(1'b0, 1'b0, 1'b0);
      write_words(1);
      settle();
      check_status(1'b0, 1'b0, 1'b1);
      drain_all();
      settle();
      check_status(1'b1, 1'b0, 1'b0);
      // fill up, then strobes that must be dropped
      write_words(`FIFO_DEPTH);
      settle();
      check_status(1'b0, 1'b1, 1'b1);
      write_words(4);
      settle();
      check_status(1'b0, 1'b1, 1'b1);
      check("occupancy when full", 32'(writes_done - reads_done), 32'(`FIFO_DEPTH));
      drain_all();
      settle();
      check_status(1'b1, 1'b0, 1'b0);
      // reads on an empty FIFO
      repeat (6)
      begin
         @(negedge rd_clk);
         rd_en = 1'b1;
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
      settle();
      check("dout held", dout, dout_hold);
      check_status(1'b1, 1'b0, 1'b0);
      check("words left in model", 32'(model_q.size()), 32'd0);
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/fifo_pkg.sv
src/fifo_dpram.sv
src/fifo_wr_ctrl.sv
src/fifo_rd_ctrl.sv
src/fifo_generic.sv
src/fifo_async.sv
dv/tb_clk_gen.sv
dv/fifo_async_asserts.sv
dv/fifo_async_tb.sv

/* Makefile */
TOP := fifo_async_tb
BIN := obj_dir/V$(TOP)
SRC := flist.f $(wildcard src/*.sv src/*.svh dv/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRC)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	   --top-module $(TOP) -f flist.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
